// ==== hdl/cl_glue_pkg.sv ====
//------------------------------------------------------------
// Shared types and constants for the custom-logic glue block
// Imported by the status stages, the statistics pipes and the
// top level
//------------------------------------------------------------

package cl_glue_pkg;

   localparam int NUM_SCRB_CH      = 4;
   localparam int NUM_STAT_CH      = 3;
   localparam int STAT_STAGES_DFLT = 4;

   // Scrubber channel, also used as the debug memory-select code
   typedef enum logic [2:0]
   {
      CH_A = 3'd0,
      CH_B = 3'd1,
      CH_D = 3'd2,
      CH_C = 3'd3
   } scrb_ch_e;

   // Decoded shell control word
   typedef struct packed
   {
      logic [NUM_SCRB_CH-1:0] scrb_en;
      logic                   dbg_en;
      scrb_ch_e               dbg_sel;
   } ctl_t;

   typedef struct packed
   {
      logic [2:0]  state;
      logic        done;
      logic [63:0] addr;
   } scrb_stat_t;

   // DDR statistics port, request and acknowledge halves
   typedef struct packed
   {
      logic        wr;
      logic        rd;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } stat_req_t;

   typedef struct packed
   {
      logic        ack;
      logic [7:0]  intr;
      logic [31:0] rdata;
   } stat_ack_t;

   localparam logic [31:0] ID0_WORD   = 32'h1d50_6789;
   localparam logic [31:0] ID1_WORD   = 32'h1d51_fedc;
   localparam logic [31:0] CL_VERSION = 32'hee_ee_ee_00;
   localparam logic [19:0] STATUS_TAG = 20'ha111_1;

endpackage

// ==== hdl/shell_in_stage.sv ====
//------------------------------------------------------------
// Input capture stage of the status path
// Registers the shell control word in decoded form, plus the
// shell DDR-ready level and the FLR request
//------------------------------------------------------------

`timescale 1ns/1ps

module shell_in_stage
(
   input  logic                clk,
   input  logic                sync_rst_n,
   input  logic [31:0]         sh_cl_ctl0,
   input  logic                sh_cl_ddr_is_ready,
   input  logic                sh_cl_flr_assert,
   output cl_glue_pkg::ctl_t   ctl,
   output logic                ddr_is_ready_q,
   output logic                flr_assert_q
);

   import cl_glue_pkg::*;

   ctl_t ctl_d;

   // Control word layout
   //   31    debug enable for the ID words
   //   30:28 debug scrubber select
   //   3:0   scrubber enables, A B D C from bit 0 up
   always_comb
   begin
      ctl_d.scrb_en = sh_cl_ctl0[NUM_SCRB_CH-1:0];
      ctl_d.dbg_en  = sh_cl_ctl0[31];
      ctl_d.dbg_sel = scrb_ch_e'(sh_cl_ctl0[30:28]);
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl            <= '0;
         ddr_is_ready_q <= 1'b0;
         flr_assert_q   <= 1'b0;
      end
      else
      begin
         ctl            <= ctl_d;
         ddr_is_ready_q <= sh_cl_ddr_is_ready;
         flr_assert_q   <= sh_cl_flr_assert;
      end
   end

endmodule

// ==== hdl/status_out_stage.sv ====
//------------------------------------------------------------
// Output build stage of the status path
// Formats the status and ID words in normal or debug layout
// and generates the self-clearing FLR acknowledge
//------------------------------------------------------------

`timescale 1ns/1ps

module status_out_stage
(
   input  logic                     clk,
   input  logic                     sync_rst_n,
   input  cl_glue_pkg::ctl_t        ctl,
   input  logic                     ddr_is_ready_q,
   input  logic [2:0]               lcl_ddr_is_ready,
   input  logic                     flr_assert_q,
   input  cl_glue_pkg::scrb_stat_t [cl_glue_pkg::NUM_SCRB_CH-1:0] scrb,
   output logic [31:0]              cl_sh_status0,
   output logic [31:0]              cl_sh_id0,
   output logic [31:0]              cl_sh_id1,
   output logic                     cl_sh_flr_done
);

   import cl_glue_pkg::*;

   logic [3:0]  ready_vec;
   logic [3:0]  done_vec;
   logic [63:0] sel_addr;
   logic [31:0] status_d;

   // Shell-side DDR sits at position 2, the local controllers around it
   assign ready_vec = {lcl_ddr_is_ready[2], ddr_is_ready_q, lcl_ddr_is_ready[1:0]};
   assign done_vec  = {scrb[CH_C].done, scrb[CH_D].done, scrb[CH_B].done, scrb[CH_A].done};

   // Unnamed select codes fall back to channel A
   always_comb
   begin
      case (ctl.dbg_sel)
         CH_B:    sel_addr = scrb[CH_B].addr;
         CH_D:    sel_addr = scrb[CH_D].addr;
         CH_C:    sel_addr = scrb[CH_C].addr;
         default: sel_addr = scrb[CH_A].addr;
      endcase
   end

   always_comb
   begin
      if (ctl.dbg_en)
         status_d = {1'b0, scrb[CH_C].state,
                     1'b0, scrb[CH_D].state,
                     1'b0, scrb[CH_B].state,
                     1'b0, scrb[CH_A].state,
                     4'h0, 4'hf, done_vec, ready_vec};
      else
         status_d = {STATUS_TAG, 4'hf, done_vec, ready_vec};
   end

   //------------------------------------------------------------
   // Output registers
   //------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         cl_sh_status0  <= '0;
         cl_sh_id0      <= '0;
         cl_sh_id1      <= '0;
         cl_sh_flr_done <= 1'b0;
      end
      else
      begin
         cl_sh_status0  <= status_d;
         cl_sh_id0      <= ctl.dbg_en ? sel_addr[31:0]  : ID0_WORD;
         cl_sh_id1      <= ctl.dbg_en ? sel_addr[63:32] : ID1_WORD;
         // Pulses every other cycle while the request is held
         cl_sh_flr_done <= flr_assert_q & ~cl_sh_flr_done;
      end
   end

endmodule

// ==== hdl/stat_pipe.sv ====
//------------------------------------------------------------
// Register pipe for one DDR statistics channel
// Requests shift toward the DDR port, acknowledges shift back
// toward the shell, STAGES cycles each way
//------------------------------------------------------------

`timescale 1ns/1ps

module stat_pipe
#(
   parameter int STAGES = cl_glue_pkg::STAT_STAGES_DFLT
)
(
   input  logic                    clk,
   input  logic                    sync_rst_n,
   input  cl_glue_pkg::stat_req_t  sh_stat_req,
   input  cl_glue_pkg::stat_ack_t  ddr_stat_ack,
   output cl_glue_pkg::stat_req_t  ddr_stat_req,
   output cl_glue_pkg::stat_ack_t  sh_stat_ack
);

   import cl_glue_pkg::*;

   stat_req_t req_q [STAGES];
   stat_ack_t ack_q [STAGES];

   // No stall, every stage moves on each clock
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         for (int i = 0; i < STAGES; i++)
         begin
            req_q[i] <= '0;
            ack_q[i] <= '0;
         end
      end
      else
      begin
         req_q[0] <= sh_stat_req;
         ack_q[0] <= ddr_stat_ack;
         for (int i = 1; i < STAGES; i++)
         begin
            req_q[i] <= req_q[i-1];
            ack_q[i] <= ack_q[i-1];
         end
      end
   end

   assign ddr_stat_req = req_q[STAGES-1];
   assign sh_stat_ack  = ack_q[STAGES-1];

endmodule

// ==== hdl/cl_glue_top.sv ====
//------------------------------------------------------------
// Custom-logic glue top level
// Status path of two register stages plus one statistics
// pipe per DDR statistics channel
//------------------------------------------------------------

`timescale 1ns/1ps

module cl_glue_top
#(
   parameter int STAT_STAGES = cl_glue_pkg::STAT_STAGES_DFLT
)
(
   input  logic        clk,
   input  logic        sync_rst_n,
   input  logic [31:0] sh_cl_ctl0,
   input  logic        sh_cl_ddr_is_ready,
   input  logic [2:0]  lcl_ddr_is_ready,
   input  logic        sh_cl_flr_assert,
   input  cl_glue_pkg::scrb_stat_t [cl_glue_pkg::NUM_SCRB_CH-1:0] scrb,
   input  cl_glue_pkg::stat_req_t  [cl_glue_pkg::NUM_STAT_CH-1:0] sh_stat_req,
   input  cl_glue_pkg::stat_ack_t  [cl_glue_pkg::NUM_STAT_CH-1:0] ddr_stat_ack,
   output logic [cl_glue_pkg::NUM_SCRB_CH-1:0] scrb_en,
   output logic        cl_sh_flr_done,
   output logic [31:0] cl_sh_status0,
   output logic [31:0] cl_sh_status1,
   output logic [31:0] cl_sh_id0,
   output logic [31:0] cl_sh_id1,
   output cl_glue_pkg::stat_req_t  [cl_glue_pkg::NUM_STAT_CH-1:0] ddr_stat_req,
   output cl_glue_pkg::stat_ack_t  [cl_glue_pkg::NUM_STAT_CH-1:0] sh_stat_ack
);

   import cl_glue_pkg::*;

   ctl_t ctl;
   logic ddr_is_ready_q;
   logic flr_assert_q;

   //------------------------------------------------------------
   // Status path
   //------------------------------------------------------------
   shell_in_stage in_stage_i
   (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .ctl                (ctl),
      .ddr_is_ready_q     (ddr_is_ready_q),
      .flr_assert_q       (flr_assert_q)
   );

   status_out_stage out_stage_i
   (
      .clk              (clk),
      .sync_rst_n       (sync_rst_n),
      .ctl              (ctl),
      .ddr_is_ready_q   (ddr_is_ready_q),
      .lcl_ddr_is_ready (lcl_ddr_is_ready),
      .flr_assert_q     (flr_assert_q),
      .scrb             (scrb),
      .cl_sh_status0    (cl_sh_status0),
      .cl_sh_id0        (cl_sh_id0),
      .cl_sh_id1        (cl_sh_id1),
      .cl_sh_flr_done   (cl_sh_flr_done)
   );

   // Scrubber enables leave straight from the capture register
   assign scrb_en       = ctl.scrb_en;
   assign cl_sh_status1 = CL_VERSION;

   //------------------------------------------------------------
   // Statistics pipes, one per channel
   //------------------------------------------------------------
   for (genvar i = 0; i < NUM_STAT_CH; i++)
   begin : g_stat
      stat_pipe #(.STAGES(STAT_STAGES)) stat_pipe_i
      (
         .clk          (clk),
         .sync_rst_n   (sync_rst_n),
         .sh_stat_req  (sh_stat_req[i]),
         .ddr_stat_ack (ddr_stat_ack[i]),
         .ddr_stat_req (ddr_stat_req[i]),
         .sh_stat_ack  (sh_stat_ack[i])
      );
   end

endmodule

// ==== dv/tb_clk_gen.sv ====
//------------------------------------------------------------
// Testbench clock source, free-running from time zero
//------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen
#(
   parameter int PERIOD_NS = 20
)
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD_NS / 2) clk = ~clk;
   end

endmodule

// ==== dv/cl_glue_checker.sv ====
//------------------------------------------------------------
// Concurrent assertions on FLR acknowledge and statistics
// pipe timing, bound into status_out_stage and stat_pipe
//------------------------------------------------------------

`timescale 1ns/1ps

module cl_glue_checker
#(
   parameter int STAGES = 1
)
(
   input logic                   clk,
   input logic                   sync_rst_n,
   input logic                   flr_assert_q,
   input logic                   cl_sh_flr_done,
   input cl_glue_pkg::stat_req_t sh_stat_req,
   input cl_glue_pkg::stat_req_t ddr_stat_req,
   input cl_glue_pkg::stat_ack_t ddr_stat_ack,
   input cl_glue_pkg::stat_ack_t sh_stat_ack
);

   // FLR acknowledge is a single-cycle pulse
   flr_single_a: assert property (@(posedge clk) disable iff (!sync_rst_n)
      cl_sh_flr_done |=> !cl_sh_flr_done)
      else $error("cl_sh_flr_done high on two consecutive cycles");

   flr_cause_a: assert property (@(posedge clk) disable iff (!sync_rst_n)
      $rose(cl_sh_flr_done) |-> $past(flr_assert_q))
      else $error("cl_sh_flr_done rose without a registered FLR request");

   // Both directions are a plain shift of STAGES registers
   req_delay_a: assert property (@(posedge clk) disable iff (!sync_rst_n)
      ddr_stat_req == $past(sh_stat_req, STAGES))
      else $error("ddr_stat_req differs from sh_stat_req %0d cycles earlier", STAGES);

   ack_delay_a: assert property (@(posedge clk) disable iff (!sync_rst_n)
      sh_stat_ack == $past(ddr_stat_ack, STAGES))
      else $error("sh_stat_ack differs from ddr_stat_ack %0d cycles earlier", STAGES);

endmodule

bind stat_pipe cl_glue_checker #(.STAGES(STAGES)) pipe_chk_i
(
   .clk            (clk),
   .sync_rst_n     (sync_rst_n),
   .flr_assert_q   (1'b0),
   .cl_sh_flr_done (1'b0),
   .sh_stat_req    (sh_stat_req),
   .ddr_stat_req   (ddr_stat_req),
   .ddr_stat_ack   (ddr_stat_ack),
   .sh_stat_ack    (sh_stat_ack)
);

bind status_out_stage cl_glue_checker #(.STAGES(1)) flr_chk_i
(
   .clk            (clk),
   .sync_rst_n     (sync_rst_n),
   .flr_assert_q   (flr_assert_q),
   .cl_sh_flr_done (cl_sh_flr_done),
   .sh_stat_req    ('0),
   .ddr_stat_req   ('0),
   .ddr_stat_ack   ('0),
   .sh_stat_ack    ('0)
);

// ==== dv/cl_glue_tb.sv ====
//------------------------------------------------------------
// Testbench for the custom-logic glue top level
// Reads stimulus and expected values from dv/cl_glue_tests.txt
// and checks the status path, FLR pulse and statistics pipes
//------------------------------------------------------------

`timescale 1ns/1ps

module cl_glue_tb;

   import cl_glue_pkg::*;

   localparam int HIST_DEPTH = 64;

   logic                         clk;
   logic                         sync_rst_n;
   logic [31:0]                  sh_cl_ctl0;
   logic                         sh_cl_ddr_is_ready;
   logic [2:0]                   lcl_ddr_is_ready;
   logic                         sh_cl_flr_assert;
   scrb_stat_t [NUM_SCRB_CH-1:0] scrb;
   stat_req_t  [NUM_STAT_CH-1:0] sh_stat_req;
   stat_ack_t  [NUM_STAT_CH-1:0] ddr_stat_ack;
   logic [NUM_SCRB_CH-1:0]       scrb_en;
   logic                         cl_sh_flr_done;
   logic [31:0]                  cl_sh_status0;
   logic [31:0]                  cl_sh_status1;
   logic [31:0]                  cl_sh_id0;
   logic [31:0]                  cl_sh_id1;
   stat_req_t  [NUM_STAT_CH-1:0] ddr_stat_req;
   stat_ack_t  [NUM_STAT_CH-1:0] sh_stat_ack;

   // Items sent per channel in the current statistics test
   stat_req_t req_hist [NUM_STAT_CH][HIST_DEPTH];
   stat_ack_t ack_hist [NUM_STAT_CH][HIST_DEPTH];

   integer seed = 32'h37d2;
   int     fd;
   int     cycle_cnt   = 0;
   int     cycle_limit = 0;
   int     test_num    = 0;
   int     pass_cnt    = 0;
   int     fail_cnt    = 0;
   int     test_errs   = 0;

   tb_clk_gen #(.PERIOD_NS(20)) clk_gen_i (.clk(clk));

   cl_glue_top dut_i
   (
      .clk                (clk),
      .sync_rst_n         (sync_rst_n),
      .sh_cl_ctl0         (sh_cl_ctl0),
      .sh_cl_ddr_is_ready (sh_cl_ddr_is_ready),
      .lcl_ddr_is_ready   (lcl_ddr_is_ready),
      .sh_cl_flr_assert   (sh_cl_flr_assert),
      .scrb               (scrb),
      .sh_stat_req        (sh_stat_req),
      .ddr_stat_ack       (ddr_stat_ack),
      .scrb_en            (scrb_en),
      .cl_sh_flr_done     (cl_sh_flr_done),
      .cl_sh_status0      (cl_sh_status0),
      .cl_sh_status1      (cl_sh_status1),
      .cl_sh_id0          (cl_sh_id0),
      .cl_sh_id1          (cl_sh_id1),
      .ddr_stat_req       (ddr_stat_req),
      .sh_stat_ack        (sh_stat_ack)
   );

   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
      begin
         $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
         $display("test failed");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
      if (actual !== expected)
      begin
         $display("FAILED at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
         test_errs++;
      end
   endtask

   task automatic finish_test(input string kind);
      test_num++;
      if (test_errs == 0)
      begin
         pass_cnt++;
         $display("Test %0d %s: ok", test_num, kind);
      end
      else
      begin
         fail_cnt++;
         $display("Test %0d %s: %0d mismatches", test_num, kind, test_errs);
      end
      test_errs = 0;
   endtask

   task automatic count_test_lines(output int n);
      int               cfd;
      int               rc;
      logic [7:0]       op;
      logic [8*128-1:0] rest;
      n = 0;
      cfd = $fopen("dv/cl_glue_tests.txt", "r");
      if (cfd != 0)
      begin
         while ($fscanf(cfd, " %c", op) == 1)
         begin
            rc = $fgets(rest, cfd);
            if (op != "#")
               n++;
         end
         $fclose(cfd);
      end
   endtask

   task automatic set_scrubber(input logic [1:0] ch, input logic [2:0] state,
                               input logic done, input logic [31:0] hi, lo);
      @(posedge clk);
      scrb[ch].state <= state;
      scrb[ch].done  <= done;
      scrb[ch].addr  <= {hi, lo};
   endtask

   // Shell inputs reach scrb_en after one register and the status words after two
   task automatic status_test(input logic [31:0] ctl0, input logic shell_rdy,
                              input logic [2:0] lcl_rdy, input logic [3:0] exp_en,
                              input logic [31:0] exp_status0, exp_id0, exp_id1,
                              input logic [31:0] exp_status1, input logic exp_flr);
      @(posedge clk);
      sh_cl_ctl0         <= ctl0;
      sh_cl_ddr_is_ready <= shell_rdy;
      lcl_ddr_is_ready   <= lcl_rdy;
      @(posedge clk);
      @(negedge clk);
      check_val("scrb_en", 64'(scrb_en), 64'(exp_en));
      @(posedge clk);
      @(negedge clk);
      check_val("cl_sh_status0", 64'(cl_sh_status0), 64'(exp_status0));
      check_val("cl_sh_id0", 64'(cl_sh_id0), 64'(exp_id0));
      check_val("cl_sh_id1", 64'(cl_sh_id1), 64'(exp_id1));
      check_val("cl_sh_status1", 64'(cl_sh_status1), 64'(exp_status1));
      check_val("cl_sh_flr_done", 64'(cl_sh_flr_done), 64'(exp_flr));
   endtask

   task automatic flr_pulse_test(input int hold, input int exp_pulses, input int exp_first);
      int k;
      int pulses;
      int first;
      pulses = 0;
      first  = -1;
      @(posedge clk);
      sh_cl_flr_assert <= 1'b1;
      for (k = 1; k <= hold + 4; k++)
      begin
         @(posedge clk);
         if (k == hold)
            sh_cl_flr_assert <= 1'b0;
         @(negedge clk);
         if (cl_sh_flr_done)
         begin
            pulses++;
            if (first < 0)
               first = k;
         end
      end
      check_val("cl_sh_flr_done pulse count", 64'(pulses), 64'(exp_pulses));
      check_val("cl_sh_flr_done first pulse delay", 64'(first), 64'(exp_first));
   endtask

   // Back-to-back random items on every channel and idle cycles while the pipe drains
   task automatic stat_stream_test(input int count, input int lat);
      int          k;
      int          ch;
      logic [31:0] r0;
      logic [31:0] r1;
      stat_req_t   req_v;
      stat_ack_t   ack_v;
      if (count > HIST_DEPTH)
      begin
         $display("Statistics test asks for %0d items, the history holds %0d", count, HIST_DEPTH);
         test_errs++;
      end
      else
      begin
         for (k = 0; k < count + lat; k++)
         begin
            @(posedge clk);
            for (ch = 0; ch < NUM_STAT_CH; ch++)
            begin
               req_v = '0;
               ack_v = '0;
               if (k < count)
               begin
                  r0    = $random(seed);
                  r1    = $random(seed);
                  req_v = {r1[9:0], r0};
                  r0    = $random(seed);
                  r1    = $random(seed);
                  ack_v = {r1[8:0], r0};
                  req_hist[ch][k] = req_v;
                  ack_hist[ch][k] = ack_v;
               end
               sh_stat_req[ch]  <= req_v;
               ddr_stat_ack[ch] <= ack_v;
            end
            @(negedge clk);
            if (k >= lat)
            begin
               for (ch = 0; ch < NUM_STAT_CH; ch++)
               begin
                  check_val($sformatf("ddr_stat_req[%0d]", ch), 64'(ddr_stat_req[ch]),
                            64'(req_hist[ch][k-lat]));
                  check_val($sformatf("sh_stat_ack[%0d]", ch), 64'(sh_stat_ack[ch]),
                            64'(ack_hist[ch][k-lat]));
               end
            end
         end
      end
   endtask

   task automatic run_test_file();
      logic [7:0]       op;
      logic [8*128-1:0] rest;
      int               rc;
      logic [31:0]      v0, v1, v2, v3, v4, v5, v6, v7, v8;
      while ($fscanf(fd, " %c", op) == 1)
      begin
         if (op == "#")
            rc = $fgets(rest, fd);
         else if (op == "A")
         begin
            rc = $fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4);
            if (rc == 5)
               set_scrubber(v0[1:0], v1[2:0], v2[0], v3, v4);
            else
            begin
               $display("Tests file line with opcode A has missing fields");
               fail_cnt++;
            end
         end
         else if (op == "S")
         begin
            rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                         v0, v1, v2, v3, v4, v5, v6, v7, v8);
            if (rc != 9)
               $display("Tests file line with opcode S has missing fields");
            else
               status_test(v0, v1[0], v2[2:0], v3[3:0], v4, v5, v6, v7, v8[0]);
            test_errs += (rc != 9) ? 1 : 0;
            finish_test("status");
         end
         else if (op == "F")
         begin
            rc = $fscanf(fd, "%h %h %h", v0, v1, v2);
            if (rc != 3)
               $display("Tests file line with opcode F has missing fields");
            else
               flr_pulse_test(int'(v0), int'(v1), int'(v2));
            test_errs += (rc != 3) ? 1 : 0;
            finish_test("flr");
         end
         else if (op == "P")
         begin
            rc = $fscanf(fd, "%h %h", v0, v1);
            if (rc != 2)
               $display("Tests file line with opcode P has missing fields");
            else
               stat_stream_test(int'(v0), int'(v1));
            test_errs += (rc != 2) ? 1 : 0;
            finish_test("stat pipe");
         end
         else
         begin
            $display("Tests file holds an unknown opcode '%c'", op);
            rc = $fgets(rest, fd);
            fail_cnt++;
         end
      end
   endtask

   initial
   begin
      int n_lines;
      sync_rst_n         <= 1'b0;
      sh_cl_ctl0         <= '0;
      sh_cl_ddr_is_ready <= 1'b0;
      lcl_ddr_is_ready   <= '0;
      sh_cl_flr_assert   <= 1'b0;
      scrb               <= '0;
      sh_stat_req        <= '0;
      ddr_stat_ack       <= '0;
      count_test_lines(n_lines);
      fd = $fopen("dv/cl_glue_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open dv/cl_glue_tests.txt for reading");
         $display("test failed");
         $finish;
      end
      else
      begin
         cycle_limit = 40 * n_lines + 100;
         repeat (10) @(posedge clk);
         sync_rst_n <= 1'b1;
         run_test_file();
         $fclose(fd);
         $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
         if (fail_cnt == 0 && test_num > 0)
            $display("test passed");
         else
            $display("test failed");
         $finish;
      end
   end

endmodule

// ==== dv/cl_glue_tests.txt ====
# A ch state done addr_hi addr_lo sets one scrubber; S ctl0 shell_rdy lcl_rdy then expected
#   scrb_en status0 id0 id1 status1 flr_done; F hold then pulses first_delay; P count latency
A 0 5 1 01234567 89abcdef
A 1 2 0 11112222 33334444
A 2 7 1 deadbeef cafef00d
A 3 3 0 55aa55aa 0f0f0f0f
S 00000000 0 0 0 a1111f50 1d506789 1d51fedc eeeeee00 0
S 0000000a 1 0 a a1111f54 1d506789 1d51fedc eeeeee00 0
S 00000005 0 7 5 a1111f5b 1d506789 1d51fedc eeeeee00 0
S 0ffffff3 1 5 3 a1111f5d 1d506789 1d51fedc eeeeee00 0
S 8000000f 1 7 f 37250f5f 89abcdef 01234567 eeeeee00 0
S 90000001 0 0 1 37250f50 33334444 11112222 eeeeee00 0
S a0000002 1 2 2 37250f56 cafef00d deadbeef eeeeee00 0
S b0000004 0 4 4 37250f58 0f0f0f0f 55aa55aa eeeeee00 0
S d0000008 1 1 8 37250f55 89abcdef 01234567 eeeeee00 0
S f0000000 0 0 0 37250f50 89abcdef 01234567 eeeeee00 0
A 1 6 1 98765432 10fedcba
S 90000000 1 3 0 37650f77 10fedcba 98765432 eeeeee00 0
S 00000000 0 0 0 a1111f70 1d506789 1d51fedc eeeeee00 0
F 6 3 2
F 4 2 2
F 1 1 2
P 1e 4
P 0c 4

// ==== files.f ====
hdl/cl_glue_pkg.sv
hdl/shell_in_stage.sv
hdl/status_out_stage.sv
hdl/stat_pipe.sv
hdl/cl_glue_top.sv
dv/tb_clk_gen.sv
dv/cl_glue_checker.sv
dv/cl_glue_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the glue-logic testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cl_glue_tb -f files.f -o cl_glue_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/cl_glue_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "test passed" sim.log; then
   exit 0
fi
exit 1
